// ==== source/dwarf_line_pkg.sv ====
// DWARF line-table accelerator shared definitions
// Bus lane codes, register map, opcodes, field widths and the structs between blocks

package dwarf_line_pkg;

    // Lane codes of the host write and read strobes
    localparam logic [1:0] RW_8_BIT  = 2'h0;
    localparam logic [1:0] RW_16_BIT = 2'h1;
    localparam logic [1:0] RW_32_BIT = 2'h2;
    localparam logic [1:0] RW_NONE   = 2'h3;

    localparam logic [5:0] REG_PROGRAM_HEADER    = 6'h0;
    localparam logic [5:0] REG_PROGRAM_CODE      = 6'h1;
    localparam logic [5:0] REG_AM_ADDRESS        = 6'h2;
    localparam logic [5:0] REG_AM_FILE_DISCRIM   = 6'h3;
    localparam logic [5:0] REG_AM_LINE_COL_FLAGS = 6'h4;
    localparam logic [5:0] REG_STATUS            = 6'h5;

    // Standard opcodes from DWARF v5
    localparam logic [7:0] DW_LNS_COPY               = 8'h01;
    localparam logic [7:0] DW_LNS_ADVANCE_PC         = 8'h02;
    localparam logic [7:0] DW_LNS_ADVANCE_LINE       = 8'h03;
    localparam logic [7:0] DW_LNS_SET_FILE           = 8'h04;
    localparam logic [7:0] DW_LNS_SET_COLUMN         = 8'h05;
    localparam logic [7:0] DW_LNS_NEGATE_STMT        = 8'h06;
    localparam logic [7:0] DW_LNS_SET_BASIC_BLOCK    = 8'h07;
    localparam logic [7:0] DW_LNS_FIXED_ADVANCE_PC   = 8'h09;
    localparam logic [7:0] DW_LNS_SET_PROLOGUE_END   = 8'h0A;
    localparam logic [7:0] DW_LNS_SET_EPILOGUE_BEGIN = 8'h0B;
    localparam logic [7:0] DW_LNS_SET_ISA            = 8'h0C;

    // Extended opcodes follow a zero byte and a LEB128 length
    localparam logic [7:0] EXTENDED_OPCODE_START    = 8'h00;
    localparam logic [7:0] DW_LNE_END_SEQUENCE      = 8'h01;
    localparam logic [7:0] DW_LNE_SET_ADDRESS       = 8'h02;
    localparam logic [7:0] DW_LNE_SET_DISCRIMINATOR = 8'h04;

    localparam int OPERAND_WIDTH = 28;
    localparam int ADDRESS_WIDTH = 28;
    localparam int FILE_WIDTH    = 16;
    localparam int LINE_WIDTH    = 16;
    localparam int COLUMN_WIDTH  = 10;
    localparam int DISCRIM_WIDTH = 16;

    // Operand states are ordered so that the next byte is the next value
    typedef enum logic [4:0] {
        STATE_READY,
        STATE_EXTENDED_OPCODE,
        STATE_PAUSE_COPY,
        STATE_PAUSE_END,
        STATE_LEB_BYTE0,
        STATE_LEB_BYTE1,
        STATE_LEB_BYTE2,
        STATE_LEB_BYTE3,
        STATE_LEB_OVERFLOW,
        STATE_U16_BYTE0,
        STATE_U16_BYTE1,
        STATE_U64_BYTE0,
        STATE_U64_BYTE1,
        STATE_U64_BYTE2,
        STATE_U64_BYTE3,
        STATE_U64_BYTE4,
        STATE_U64_BYTE5,
        STATE_U64_BYTE6,
        STATE_U64_BYTE7,
        STATE_EXEC
    } parse_state_t;

    typedef enum logic [2:0] {
        INSTR_NOP,
        INSTR_ADVANCE_PC,
        INSTR_ADVANCE_LINE,
        INSTR_SET_FILE,
        INSTR_SET_COLUMN,
        INSTR_EXTENDED,
        INSTR_SET_ADDRESS,
        INSTR_SET_DISCRIMINATOR
    } instr_t;

    typedef struct packed {
        logic        write_header;
        logic        write_code;
        logic        write_status;
        logic [1:0]  width;
        logic [31:0] data;
    } host_cmd_t;

    typedef struct packed {
        logic         parse_byte;
        parse_state_t state;
        logic         exec;
        instr_t       instr;
        logic [7:0]   std_opcode;
        logic         in_end_pause;
        logic         paused;
    } parse_step_t;

    typedef struct packed {
        logic [ADDRESS_WIDTH-1:0] address;
        logic [FILE_WIDTH-1:0]    file;
        logic [LINE_WIDTH-1:0]    line;
        logic [COLUMN_WIDTH-1:0]  column;
        logic [DISCRIM_WIDTH-1:0] discriminator;
        logic                     is_stmt;
        logic                     basic_block;
        logic                     end_sequence;
        logic                     prologue_end;
        logic                     epilogue_begin;
    } am_regs_t;

endpackage

// ==== source/code_buffer.sv ====
// Code buffer
// Holds the last code word written by the host and hands out one byte per cycle

`timescale 1ns/1ps

module code_buffer import dwarf_line_pkg::*; (
    input  logic        clk,
    input  logic        reset_this_cycle,
    input  host_cmd_t   cmd,
    input  parse_step_t step,
    output logic [7:0]  current_byte,
    output logic        byte_valid
);
    logic [31:0] code_word;
    logic [1:0]  code_width;
    logic [2:0]  ptr;

    // The pointer runs one past the last byte so a drained buffer is visible
    always_ff @(posedge clk) begin
        if (reset_this_cycle || cmd.write_header) begin
            code_width <= RW_NONE;
            ptr        <= 3'd0;
        end else if (cmd.write_code) begin
            code_width <= cmd.width;
            ptr        <= 3'd0;
        end else if (step.parse_byte) begin
            ptr <= ptr + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.write_code) begin
            case (cmd.width)
                RW_8_BIT:  code_word <= {24'h0, cmd.data[7:0]};
                RW_16_BIT: code_word <= {16'h0, cmd.data[15:0]};
                default:   code_word <= cmd.data;
            endcase
        end
    end

    assign current_byte = ptr[2] ? 8'h00 : code_word[ptr[1:0]*8 +: 8];

    always_comb begin
        case (ptr)
            3'd0:       byte_valid = code_width != RW_NONE;
            3'd1:       byte_valid = code_width == RW_16_BIT || code_width == RW_32_BIT;
            3'd2, 3'd3: byte_valid = code_width == RW_32_BIT;
            default:    byte_valid = 1'b0;
        endcase
    end

endmodule

// ==== source/opcode_sequencer.sv ====
// Opcode sequencer
// Parse FSM that decodes opcodes, steps through operand bytes and pauses on emitted rows

`timescale 1ns/1ps

module opcode_sequencer import dwarf_line_pkg::*; (
    input  logic        clk,
    input  logic        reset_this_cycle,
    input  host_cmd_t   cmd,
    input  logic [7:0]  current_byte,
    input  logic        byte_valid,
    output parse_step_t step,
    output logic        emit_row,
    output logic        user_interrupt
);
    parse_state_t state;
    parse_state_t state_next;
    instr_t       instr;
    instr_t       instr_next;
    logic         write_any;
    logic         paused;
    logic         exec;
    logic         parse_byte;
    logic         parse_std;
    logic         parse_ext;
    logic         leb_last;

    // Any host write stalls the parser for that cycle
    assign write_any  = cmd.width != RW_NONE;
    assign paused     = state == STATE_PAUSE_COPY || state == STATE_PAUSE_END;
    assign exec       = !write_any && state == STATE_EXEC;
    assign parse_byte = !write_any && !paused && state != STATE_EXEC && byte_valid;
    assign parse_std  = parse_byte && state == STATE_READY;
    assign parse_ext  = parse_byte && state == STATE_EXTENDED_OPCODE;
    assign leb_last   = !current_byte[7];

    always_comb begin
        state_next = state;
        instr_next = instr;
        if (exec) begin
            // The length of an extended opcode has been read, so the opcode comes next
            state_next = instr == INSTR_EXTENDED ? STATE_EXTENDED_OPCODE : STATE_READY;
        end else if (parse_std) begin
            case (current_byte)
                DW_LNS_COPY: state_next = STATE_PAUSE_COPY;
                DW_LNS_ADVANCE_PC: begin
                    state_next = STATE_LEB_BYTE0;
                    instr_next = INSTR_ADVANCE_PC;
                end
                DW_LNS_ADVANCE_LINE: begin
                    state_next = STATE_LEB_BYTE0;
                    instr_next = INSTR_ADVANCE_LINE;
                end
                DW_LNS_SET_FILE: begin
                    state_next = STATE_LEB_BYTE0;
                    instr_next = INSTR_SET_FILE;
                end
                DW_LNS_SET_COLUMN: begin
                    state_next = STATE_LEB_BYTE0;
                    instr_next = INSTR_SET_COLUMN;
                end
                DW_LNS_FIXED_ADVANCE_PC: begin
                    state_next = STATE_U16_BYTE0;
                    instr_next = INSTR_ADVANCE_PC;
                end
                // The ISA operand is parsed and thrown away
                DW_LNS_SET_ISA: begin
                    state_next = STATE_LEB_BYTE0;
                    instr_next = INSTR_NOP;
                end
                EXTENDED_OPCODE_START: begin
                    state_next = STATE_LEB_BYTE0;
                    instr_next = INSTR_EXTENDED;
                end
                default: ;
            endcase
        end else if (parse_ext) begin
            case (current_byte)
                DW_LNE_END_SEQUENCE: state_next = STATE_PAUSE_END;
                DW_LNE_SET_ADDRESS: begin
                    state_next = STATE_U64_BYTE0;
                    instr_next = INSTR_SET_ADDRESS;
                end
                DW_LNE_SET_DISCRIMINATOR: begin
                    state_next = STATE_LEB_BYTE0;
                    instr_next = INSTR_SET_DISCRIMINATOR;
                end
                default: state_next = STATE_READY;
            endcase
        end else if (parse_byte) begin
            case (state)
                STATE_LEB_BYTE0, STATE_LEB_BYTE1, STATE_LEB_BYTE2:
                    state_next = leb_last ? STATE_EXEC : parse_state_t'(state + 5'd1);
                STATE_LEB_BYTE3, STATE_LEB_OVERFLOW:
                    state_next = leb_last ? STATE_EXEC : STATE_LEB_OVERFLOW;
                STATE_U16_BYTE1, STATE_U64_BYTE7: state_next = STATE_EXEC;
                // Remaining fixed-width bytes step to the following byte state
                default: state_next = parse_state_t'(state + 5'd1);
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_this_cycle || cmd.write_header || cmd.write_status) begin
            state <= STATE_READY;
            instr <= INSTR_NOP;
        end else begin
            state <= state_next;
            instr <= instr_next;
        end
    end

    // The interrupt survives a header write and is only acknowledged through STATUS
    always_ff @(posedge clk) begin
        if (reset_this_cycle || cmd.write_status) begin
            user_interrupt <= 1'b0;
        end else if (parse_byte && (state_next == STATE_PAUSE_COPY ||
                                    state_next == STATE_PAUSE_END)) begin
            user_interrupt <= 1'b1;
        end
    end

    assign emit_row = paused;

    assign step.parse_byte   = parse_byte;
    assign step.state        = state;
    assign step.exec         = exec;
    assign step.instr        = instr;
    assign step.std_opcode   = parse_std ? current_byte : 8'h00;
    assign step.in_end_pause = state == STATE_PAUSE_END;
    assign step.paused       = paused;

endmodule

// ==== source/operand_assembler.sv ====
// Operand assembler
// Builds LEB128 and little-endian fixed-width operands one byte per cycle

`timescale 1ns/1ps

module operand_assembler import dwarf_line_pkg::*; (
    input  logic                     clk,
    input  logic                     reset_this_cycle,
    input  host_cmd_t                cmd,
    input  parse_step_t              step,
    input  logic [7:0]               current_byte,
    output logic [OPERAND_WIDTH-1:0] operand
);
    logic                     leb_signed;
    logic [OPERAND_WIDTH-1:0] fill;

    // Only advance_line carries a signed LEB operand
    assign leb_signed = step.instr == INSTR_ADVANCE_LINE;
    assign fill       = {OPERAND_WIDTH{leb_signed && current_byte[6]}};

    always_ff @(posedge clk) begin
        if (reset_this_cycle || cmd.write_header) begin
            operand <= '0;
        end else if (step.parse_byte) begin
            case (step.state)
                STATE_LEB_BYTE0: operand <= {fill[27:7], current_byte[6:0]};
                STATE_LEB_BYTE1: operand <= {fill[27:14], current_byte[6:0], operand[6:0]};
                STATE_LEB_BYTE2: operand <= {fill[27:21], current_byte[6:0], operand[13:0]};
                STATE_LEB_BYTE3: operand <= {current_byte[6:0], operand[20:0]};
                STATE_U16_BYTE0, STATE_U64_BYTE0: operand <= {20'h0, current_byte};
                STATE_U16_BYTE1, STATE_U64_BYTE1:
                    operand <= {12'h0, current_byte, operand[7:0]};
                STATE_U64_BYTE2: operand <= {4'h0, current_byte, operand[15:0]};
                // Upper address bytes fall outside the 28-bit operand
                STATE_U64_BYTE3: operand <= {current_byte[3:0], operand[23:0]};
                default: ;
            endcase
        end
    end

endmodule

// ==== source/abstract_machine.sv ====
// Line-table abstract machine
// State registers updated by executed instructions, flag opcodes and STATUS acknowledges

`timescale 1ns/1ps

module abstract_machine import dwarf_line_pkg::*; (
    input  logic                     clk,
    input  logic                     reset_this_cycle,
    input  host_cmd_t                cmd,
    input  parse_step_t              step,
    input  logic [OPERAND_WIDTH-1:0] operand,
    input  logic                     default_is_stmt,
    output am_regs_t                 am
);
    logic [ADDRESS_WIDTH-1:1] address;
    logic [FILE_WIDTH-1:0]    file;
    logic [LINE_WIDTH-1:0]    line;
    logic [COLUMN_WIDTH-1:0]  column;
    logic [DISCRIM_WIDTH-1:0] discriminator;
    logic                     is_stmt;
    logic                     basic_block;
    logic                     prologue_end;
    logic                     epilogue_begin;
    logic                     end_restart;
    logic                     row_clear;
    logic [OPERAND_WIDTH-1:0] adder_src;
    logic [OPERAND_WIDTH-1:0] adder_sum;

    assign end_restart = cmd.write_status && step.in_end_pause;
    assign row_clear   = cmd.write_status && step.paused;

    // advance_pc and advance_line never execute together, so one adder serves both
    assign adder_src = step.instr == INSTR_ADVANCE_PC ? {address, 1'b0} : {12'h0, line};
    assign adder_sum = adder_src + operand;

    always_ff @(posedge clk) begin
        if (reset_this_cycle || cmd.write_header || end_restart) begin
            address <= '0;
            file    <= 16'd1;
            line    <= 16'd1;
            column  <= '0;
        end else if (step.exec) begin
            case (step.instr)
                INSTR_ADVANCE_PC:   address <= adder_sum[ADDRESS_WIDTH-1:1];
                INSTR_SET_ADDRESS:  address <= operand[ADDRESS_WIDTH-1:1];
                INSTR_ADVANCE_LINE: line <= adder_sum[LINE_WIDTH-1:0];
                INSTR_SET_FILE:     file <= operand[FILE_WIDTH-1:0];
                INSTR_SET_COLUMN:   column <= operand[COLUMN_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_this_cycle || cmd.write_header) begin
            is_stmt        <= !reset_this_cycle && cmd.data[0];
            basic_block    <= 1'b0;
            prologue_end   <= 1'b0;
            epilogue_begin <= 1'b0;
            discriminator  <= '0;
        end else if (row_clear) begin
            // Per-row values clear once the host has taken the row
            basic_block    <= 1'b0;
            prologue_end   <= 1'b0;
            epilogue_begin <= 1'b0;
            discriminator  <= '0;
            if (step.in_end_pause) begin
                is_stmt <= default_is_stmt;
            end
        end else begin
            if (step.exec && step.instr == INSTR_SET_DISCRIMINATOR) begin
                discriminator <= operand[DISCRIM_WIDTH-1:0];
            end
            case (step.std_opcode)
                DW_LNS_NEGATE_STMT:        is_stmt <= !is_stmt;
                DW_LNS_SET_BASIC_BLOCK:    basic_block <= 1'b1;
                DW_LNS_SET_PROLOGUE_END:   prologue_end <= 1'b1;
                DW_LNS_SET_EPILOGUE_BEGIN: epilogue_begin <= 1'b1;
                default: ;
            endcase
        end
    end

    assign am.address        = {address, 1'b0};
    assign am.file           = file;
    assign am.line           = line;
    assign am.column         = column;
    assign am.discriminator  = discriminator;
    assign am.is_stmt        = is_stmt;
    assign am.basic_block    = basic_block;
    // The flag is set for exactly as long as the end pause lasts
    assign am.end_sequence   = step.in_end_pause;
    assign am.prologue_end   = prologue_end;
    assign am.epilogue_begin = epilogue_begin;

endmodule

// ==== source/register_readback.sv ====
// Register readback
// Formats machine state into bus words and masks the lanes outside the read width

`timescale 1ns/1ps

module register_readback import dwarf_line_pkg::*; (
    input  logic [5:0]  address,
    input  logic [1:0]  data_read,
    input  am_regs_t    am,
    input  logic        default_is_stmt,
    input  logic        emit_row,
    output logic [31:0] data_out
);
    logic [31:0] word;

    always_comb begin
        case (address)
            REG_PROGRAM_HEADER:  word = {31'h0, default_is_stmt};
            REG_AM_ADDRESS:      word = {4'h0, am.address};
            REG_AM_FILE_DISCRIM: word = {am.discriminator, am.file};
            REG_AM_LINE_COL_FLAGS: begin
                word = {1'b0, am.epilogue_begin, am.prologue_end, am.end_sequence,
                        am.basic_block, am.is_stmt, am.column, am.line};
            end
            REG_STATUS:          word = {31'h0, emit_row};
            default:             word = 32'h0;
        endcase
    end

    assign data_out[7:0]   = data_read != RW_NONE ? word[7:0] : 8'h00;
    assign data_out[15:8]  = (data_read == RW_16_BIT || data_read == RW_32_BIT) ?
                             word[15:8] : 8'h00;
    assign data_out[31:16] = data_read == RW_32_BIT ? word[31:16] : 16'h0000;

endmodule

// ==== source/dwarf_line_accel.sv ====
// DWARF line-table accelerator top level
// Decodes host register writes and ties the parser, operand path and abstract machine together

`timescale 1ns/1ps

module dwarf_line_accel import dwarf_line_pkg::*; (
    input  logic        clk,
    input  logic        reset_this_cycle,
    input  logic [5:0]  address,
    input  logic [31:0] data_in,
    input  logic [1:0]  data_write,
    input  logic [1:0]  data_read,
    output logic [31:0] data_out,
    output logic        user_interrupt
);
    host_cmd_t                cmd;
    parse_step_t              step;
    am_regs_t                 am;
    logic                     write_any;
    logic                     default_is_stmt;
    logic                     emit_row;
    logic                     byte_valid;
    logic [7:0]               current_byte;
    logic [OPERAND_WIDTH-1:0] operand;

    assign write_any        = data_write != RW_NONE;
    assign cmd.write_header = write_any && address == REG_PROGRAM_HEADER;
    assign cmd.write_code   = write_any && address == REG_PROGRAM_CODE;
    assign cmd.write_status = write_any && address == REG_STATUS;
    assign cmd.width        = data_write;
    assign cmd.data         = data_in;

    // Only default_is_stmt of the program header affects execution
    always_ff @(posedge clk) begin
        if (reset_this_cycle) begin
            default_is_stmt <= 1'b0;
        end else if (cmd.write_header) begin
            default_is_stmt <= data_in[0];
        end
    end

    code_buffer code_buffer_i (
        .clk(clk), .reset_this_cycle(reset_this_cycle), .cmd(cmd), .step(step),
        .current_byte(current_byte), .byte_valid(byte_valid)
    );

    opcode_sequencer opcode_sequencer_i (
        .clk(clk), .reset_this_cycle(reset_this_cycle), .cmd(cmd),
        .current_byte(current_byte), .byte_valid(byte_valid), .step(step),
        .emit_row(emit_row), .user_interrupt(user_interrupt)
    );

    operand_assembler operand_assembler_i (
        .clk(clk), .reset_this_cycle(reset_this_cycle), .cmd(cmd), .step(step),
        .current_byte(current_byte), .operand(operand)
    );

    abstract_machine abstract_machine_i (
        .clk(clk), .reset_this_cycle(reset_this_cycle), .cmd(cmd), .step(step),
        .operand(operand), .default_is_stmt(default_is_stmt), .am(am)
    );

    register_readback register_readback_i (
        .address(address), .data_read(data_read), .am(am),
        .default_is_stmt(default_is_stmt), .emit_row(emit_row), .data_out(data_out)
    );

endmodule

// ==== sim/dwarf_line_accel_tb.sv ====
// Testbench for the DWARF line-table accelerator
// Applies a table of register writes, reads and interrupt checks to the DUT

`timescale 1ns/1ps

module dwarf_line_accel_tb import dwarf_line_pkg::*; ();

    typedef enum logic [1:0] {
        STEP_WRITE,
        STEP_READ,
        STEP_IRQ
    } step_kind_t;

    typedef struct packed {
        step_kind_t  kind;
        logic [5:0]  addr;
        logic [1:0]  width;
        logic [31:0] data;
        logic [31:0] expected;
    } step_t;

    logic        clk = 1'b0;
    logic        reset_this_cycle;
    logic [5:0]  address;
    logic [31:0] data_in;
    logic [1:0]  data_write;
    logic [1:0]  data_read;
    logic [31:0] data_out;
    logic        user_interrupt;
    logic        table_ready = 1'b0;
    step_t       steps[$];
    int          checks = 0;
    int          errors = 0;

    dwarf_line_accel dwarf_line_accel_i (
        .clk(clk), .reset_this_cycle(reset_this_cycle), .address(address),
        .data_in(data_in), .data_write(data_write), .data_read(data_read),
        .data_out(data_out), .user_interrupt(user_interrupt)
    );

    always #2 clk = ~clk;

    task automatic add_write(input logic [5:0] addr, input logic [1:0] width,
                             input logic [31:0] data);
        steps.push_back(step_t'{STEP_WRITE, addr, width, data, 32'h0});
    endtask

    task automatic add_read(input logic [5:0] addr, input logic [1:0] width,
                            input logic [31:0] expected);
        steps.push_back(step_t'{STEP_READ, addr, width, 32'h0, expected});
    endtask

    task automatic add_irq_check(input logic level);
        steps.push_back(step_t'{STEP_IRQ, 6'h0, RW_NONE, 32'h0, {31'h0, level}});
    endtask

    // Code words are little-endian, so byte 0 of the program sits in bits 7:0
    task automatic build_table();
        // Reset values
        add_read(REG_AM_FILE_DISCRIM, RW_32_BIT, 32'h0000_0001);
        add_read(REG_AM_LINE_COL_FLAGS, RW_32_BIT, 32'h0000_0001);
        add_read(REG_AM_ADDRESS, RW_32_BIT, 32'h0000_0000);
        add_read(REG_STATUS, RW_32_BIT, 32'h0000_0000);
        add_irq_check(1'b0);
        // advance_line by -3 as the two-byte LEB FD 7F, then copy
        add_write(REG_PROGRAM_CODE, RW_32_BIT, 32'h017F_FD03);
        add_irq_check(1'b1);
        add_read(REG_STATUS, RW_32_BIT, 32'h0000_0001);
        add_read(REG_AM_LINE_COL_FLAGS, RW_32_BIT, 32'h0000_FFFE);
        add_write(REG_STATUS, RW_32_BIT, 32'h0000_0000);
        add_irq_check(1'b0);
        add_read(REG_STATUS, RW_32_BIT, 32'h0000_0000);
        // advance_pc 400, set_file 5, set_column 138, fixed_advance_pc 0x1233, set_isa 5
        add_write(REG_PROGRAM_CODE, RW_32_BIT, 32'h0403_9002);
        add_write(REG_PROGRAM_CODE, RW_32_BIT, 32'h018A_0505);
        add_write(REG_PROGRAM_CODE, RW_32_BIT, 32'h0C12_3309);
        add_write(REG_PROGRAM_CODE, RW_8_BIT, 32'h0000_0005);
        add_read(REG_AM_ADDRESS, RW_32_BIT, 32'h0000_13C2);
        add_read(REG_AM_ADDRESS, RW_8_BIT, 32'h0000_00C2);
        add_read(REG_AM_FILE_DISCRIM, RW_32_BIT, 32'h0000_0005);
        add_read(REG_AM_LINE_COL_FLAGS, RW_32_BIT, 32'h008A_FFFE);
        // Header with default_is_stmt set, negate_stmt, then set_address 0xCCDDEEFF9A123457
        add_write(REG_PROGRAM_HEADER, RW_32_BIT, 32'h0000_0001);
        add_read(REG_PROGRAM_HEADER, RW_32_BIT, 32'h0000_0001);
        add_write(REG_PROGRAM_CODE, RW_32_BIT, 32'h0209_0006);
        add_write(REG_PROGRAM_CODE, RW_32_BIT, 32'h9A12_3457);
        add_write(REG_PROGRAM_CODE, RW_32_BIT, 32'hCCDD_EEFF);
        add_read(REG_AM_ADDRESS, RW_32_BIT, 32'h0A12_3456);
        // set_file 7 and set_column 7, advance_line 2, then set_discriminator 9
        add_write(REG_PROGRAM_CODE, RW_32_BIT, 32'h0705_0704);
        add_write(REG_PROGRAM_CODE, RW_16_BIT, 32'h0000_0203);
        add_write(REG_PROGRAM_CODE, RW_32_BIT, 32'h0904_0200);
        // end_sequence as 00 01 01 split over a 16-bit and an 8-bit write
        add_write(REG_PROGRAM_CODE, RW_16_BIT, 32'h0000_0100);
        add_write(REG_PROGRAM_CODE, RW_8_BIT, 32'h0000_0001);
        add_irq_check(1'b1);
        add_read(REG_STATUS, RW_32_BIT, 32'h0000_0001);
        add_read(REG_AM_LINE_COL_FLAGS, RW_32_BIT, 32'h1007_0003);
        add_read(REG_AM_FILE_DISCRIM, RW_32_BIT, 32'h0009_0007);
        add_read(REG_AM_ADDRESS, RW_32_BIT, 32'h0A12_3456);
        add_write(REG_STATUS, RW_32_BIT, 32'h0000_0000);
        add_irq_check(1'b0);
        add_read(REG_AM_ADDRESS, RW_32_BIT, 32'h0000_0000);
        add_read(REG_AM_FILE_DISCRIM, RW_32_BIT, 32'h0000_0001);
        add_read(REG_AM_LINE_COL_FLAGS, RW_32_BIT, 32'h0400_0001);
        // negate_stmt, basic_block, prologue_end, epilogue_begin, then negate_stmt and copy
        add_write(REG_PROGRAM_CODE, RW_32_BIT, 32'h0B0A_0706);
        add_read(REG_AM_LINE_COL_FLAGS, RW_32_BIT, 32'h6800_0001);
        add_write(REG_PROGRAM_CODE, RW_16_BIT, 32'h0000_0106);
        add_irq_check(1'b1);
        add_read(REG_AM_LINE_COL_FLAGS, RW_32_BIT, 32'h6C00_0001);
        add_write(REG_STATUS, RW_32_BIT, 32'h0000_0000);
        add_irq_check(1'b0);
        add_read(REG_AM_LINE_COL_FLAGS, RW_32_BIT, 32'h0400_0001);
        // Narrow code writes leave the upper flag opcodes unparsed
        add_write(REG_PROGRAM_CODE, RW_8_BIT, 32'h0B0A_0706);
        add_read(REG_AM_LINE_COL_FLAGS, RW_32_BIT, 32'h0000_0001);
        add_write(REG_PROGRAM_CODE, RW_16_BIT, 32'h0B0A_0706);
        add_read(REG_AM_LINE_COL_FLAGS, RW_32_BIT, 32'h0C00_0001);
        add_read(REG_AM_LINE_COL_FLAGS, RW_16_BIT, 32'h0000_0001);
        add_read(6'h3F, RW_32_BIT, 32'h0000_0000);
        add_irq_check(1'b0);
    endtask

    task automatic write_register(input step_t s);
        int unsigned gap;
        @(posedge clk);
        address    <= s.addr;
        data_in    <= s.data;
        data_write <= s.width;
        @(posedge clk);
        data_write <= RW_NONE;
        // Idle long enough for a full word plus its exec cycles to drain
        gap = 8 + $urandom % 4;
        repeat (gap) @(posedge clk);
    endtask

    task automatic read_register(input step_t s);
        @(posedge clk);
        address   <= s.addr;
        data_read <= s.width;
        @(negedge clk);
        checks++;
        if (data_out !== s.expected) begin
            errors++;
            $display("mismatch at time %0t: register %0h width code %0d read %08h, expected %08h",
                     $time, s.addr, s.width, data_out, s.expected);
        end
        @(posedge clk);
        data_read <= RW_NONE;
    endtask

    task automatic check_interrupt(input step_t s);
        @(negedge clk);
        checks++;
        if (user_interrupt !== s.expected[0]) begin
            errors++;
            $display("mismatch at time %0t: user_interrupt is %0b, expected %0b",
                     $time, user_interrupt, s.expected[0]);
        end
    endtask

    initial begin
        reset_this_cycle = 1'b1;
        address          = 6'h0;
        data_in          = 32'h0;
        data_write       = RW_NONE;
        data_read        = RW_NONE;
        void'($urandom(10));
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        reset_this_cycle <= 1'b0;
        foreach (steps[i]) begin
            case (steps[i].kind)
                STEP_WRITE: write_register(steps[i]);
                STEP_READ:  read_register(steps[i]);
                default:    check_interrupt(steps[i]);
            endcase
        end
        @(posedge clk);
        $display("Steps: %0d, checks: %0d, errors: %0d", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Each step needs at most 14 cycles, so 16 per step leaves some margin
    initial begin
        wait (table_ready);
        repeat (steps.size() * 16 + 16) @(posedge clk);
        $display("Watchdog expired before the step table finished");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
source/dwarf_line_pkg.sv
source/code_buffer.sv
source/opcode_sequencer.sv
source/operand_assembler.sv
source/abstract_machine.sv
source/register_readback.sv
source/dwarf_line_accel.sv
sim/dwarf_line_accel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the testbench with Verilator, run it and search the log for the pass line
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module dwarf_line_accel_tb -o sim_bin
./obj_dir/sim_bin > sim.log
cat sim.log

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
exit 1
